// ==== hw/mic_audio_defines.svh ====
`ifndef MIC_AUDIO_DEFINES_SVH
`define MIC_AUDIO_DEFINES_SVH

// number of I2S microphones sharing bclk and lrcl
`define MIC_COUNT 3

// audio_clk cycles per half bclk period
`define BCLK_HALF 16

// bclk periods per lrcl half, one frame is two slots
`define SLOT_BITS 32

// captured sample width
`define SAMPLE_W 16

// right shift applied after the 1-3-3-1 tap sum
`define FIR_SHIFT 3

`endif

// ==== hw/mic_audio_pkg.sv ====
package mic_audio_pkg;

  // speaker modulator source
  typedef enum logic {
    SRC_MIC  = 1'b0,
    SRC_TEST = 1'b1
  } source_sel_t;

  // host readout four-phase handshake
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ACK,
    RD_WAIT_DROP
  } readout_state_t;

  // position inside the left I2S slot
  typedef enum logic [1:0] {
    CAP_SYNC,
    CAP_DELAY,
    CAP_SHIFT,
    CAP_SKIP
  } capture_state_t;

endpackage

// ==== hw/i2s_mic_array.sv ====
`include "mic_audio_defines.svh"

module i2s_mic_array
  import mic_audio_pkg::*;
(
  input  logic                        audio_clk,
  input  logic                        rst,
  input  logic [`MIC_COUNT-1:0]       mic_data,
  output logic                        bclk,
  output logic                        lrcl,
  output logic                        frame_valid,
  output logic signed [`SAMPLE_W-1:0] sample_0,
  output logic signed [`SAMPLE_W-1:0] sample_1,
  output logic signed [`SAMPLE_W-1:0] sample_2
);

  localparam int DIV_W = $clog2(`BCLK_HALF);
  localparam int BIT_W = $clog2(`SLOT_BITS);
  localparam int CNT_W = $clog2(`SAMPLE_W);

  logic [DIV_W-1:0]    div_cnt;
  logic [BIT_W-1:0]    bit_cnt;
  logic [CNT_W-1:0]    shift_cnt;
  logic                half_done;
  logic                bclk_fall;
  logic                sample_en;
  logic                shift_en;
  logic                last_bit;
  capture_state_t      cap_state;
  logic [`SAMPLE_W-1:0] shift_reg [`MIC_COUNT];
  logic [`SAMPLE_W-1:0] held      [`MIC_COUNT];

  assign half_done = (div_cnt == DIV_W'(`BCLK_HALF - 1));
  assign bclk_fall = half_done && bclk;
  assign shift_en  = (cap_state == CAP_SHIFT) && sample_en;
  assign last_bit  = shift_en && (shift_cnt == CNT_W'(`SAMPLE_W - 1));

  // bclk divider, sample_en lands one cycle after each rising edge
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      div_cnt   <= '0;
      bclk      <= 1'b0;
      sample_en <= 1'b0;
    end else begin
      div_cnt   <= half_done ? '0 : div_cnt + 1'b1;
      sample_en <= half_done && !bclk;
      if (half_done) begin
        bclk <= ~bclk;
      end
    end
  end

  // word select toggles on the falling edge closing each slot
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      bit_cnt <= '0;
      lrcl    <= 1'b0;
    end else if (bclk_fall) begin
      if (bit_cnt == BIT_W'(`SLOT_BITS - 1)) begin
        bit_cnt <= '0;
        lrcl    <= ~lrcl;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      cap_state   <= CAP_SYNC;
      shift_cnt   <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= last_bit;
      case (cap_state)
        // wait for the start of a left slot
        CAP_SYNC: begin
          if (!lrcl && bit_cnt == '0) begin
            cap_state <= CAP_DELAY;
          end
        end
        // bit 0 is the I2S delay bit
        CAP_DELAY: begin
          if (sample_en) begin
            shift_cnt <= '0;
            cap_state <= CAP_SHIFT;
          end
        end
        CAP_SHIFT: begin
          if (shift_en) begin
            shift_cnt <= shift_cnt + 1'b1;
            if (last_bit) begin
              cap_state <= CAP_SKIP;
            end
          end
        end
        // padding bits, then the whole right slot
        CAP_SKIP: begin
          if (lrcl) begin
            cap_state <= CAP_SYNC;
          end
        end
        default: cap_state <= CAP_SYNC;
      endcase
    end
  end

  // all microphones shift in parallel, MSB first
  always_ff @(posedge audio_clk) begin
    for (int m = 0; m < `MIC_COUNT; m++) begin
      if (shift_en) begin
        shift_reg[m] <= {shift_reg[m][`SAMPLE_W-2:0], mic_data[m]};
      end
      if (last_bit) begin
        held[m] <= {shift_reg[m][`SAMPLE_W-2:0], mic_data[m]};
      end
    end
  end

  assign sample_0 = held[0];
  assign sample_1 = held[1];
  assign sample_2 = held[2];

  // one frame per 2048 cycles, never back to back
  a_frame_single: assert property (@(posedge audio_clk) disable iff (rst)
    frame_valid |=> !frame_valid);

endmodule

// ==== hw/fir_decimator.sv ====
`include "mic_audio_defines.svh"

module fir_decimator (
  input  logic                        audio_clk,
  input  logic                        rst,
  input  logic                        in_valid,
  input  logic signed [`SAMPLE_W-1:0] in_sample,
  output logic                        out_valid,
  output logic signed [`SAMPLE_W-1:0] out_sample
);

  // 1+3+3+1 = 8 needs three guard bits
  localparam int SUM_W = `SAMPLE_W + 3;
  localparam int TAPS  = 4;

  logic signed [`SAMPLE_W-1:0] hist [TAPS];
  logic signed [SUM_W-1:0]     ext  [TAPS];
  logic signed [SUM_W-1:0]     tap_sum;
  logic signed [SUM_W-1:0]     scaled;
  logic                        phase;
  logic                        sum_valid;

  // sign extend the history to the accumulation width
  always_comb begin
    for (int k = 0; k < TAPS; k++) begin
      ext[k] = {{(SUM_W - `SAMPLE_W){hist[k][`SAMPLE_W-1]}}, hist[k]};
    end
  end

  // 3x written as x + 2x
  assign tap_sum = ext[0] + ext[1] + (ext[1] <<< 1) + ext[2] + (ext[2] <<< 1) + ext[3];
  assign scaled  = tap_sum >>> `FIR_SHIFT;

  // history shift and decimation phase
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      for (int k = 0; k < TAPS; k++) begin
        hist[k] <= '0;
      end
      phase     <= 1'b0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= in_valid && phase;
      if (in_valid) begin
        hist[0] <= in_sample;
        for (int k = 1; k < TAPS; k++) begin
          hist[k] <= hist[k-1];
        end
        phase <= ~phase;
      end
    end
  end

  // output register, held between releases
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      out_sample <= '0;
    end else begin
      out_valid <= sum_valid;
      if (sum_valid) begin
        out_sample <= scaled[`SAMPLE_W-1:0];
      end
    end
  end

  // every result traces back to an input two cycles earlier
  a_out_after_in: assert property (@(posedge audio_clk) disable iff (rst)
    out_valid |-> $past(in_valid, 2));

endmodule

// ==== hw/pdm_modulator.sv ====
`include "mic_audio_defines.svh"

module pdm_modulator (
  input  logic                        audio_clk,
  input  logic                        rst,
  input  logic signed [`SAMPLE_W-1:0] level,
  output logic                        pdm_bit
);

  logic signed [`SAMPLE_W-1:0] level_q;
  logic [`SAMPLE_W-1:0]        offset_level;
  logic [`SAMPLE_W-1:0]        acc;
  logic [`SAMPLE_W:0]          acc_next;

  always_ff @(posedge audio_clk) begin
    level_q <= level;
  end

  // adding 32768 just flips the sign bit
  assign offset_level = {~level_q[`SAMPLE_W-1], level_q[`SAMPLE_W-2:0]};
  assign acc_next     = {1'b0, acc} + {1'b0, offset_level};

  // carry out of the accumulator is the density bit
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      acc     <= '0;
      pdm_bit <= 1'b0;
    end else begin
      acc     <= acc_next[`SAMPLE_W-1:0];
      pdm_bit <= acc_next[`SAMPLE_W];
    end
  end

endmodule

// ==== hw/sample_readout.sv ====
`include "mic_audio_defines.svh"

module sample_readout
  import mic_audio_pkg::*;
(
  input  logic                        audio_clk,
  input  logic                        rst,
  input  logic                        new_valid,
  input  logic signed [`SAMPLE_W-1:0] new_sample,
  input  logic                        rd_req,
  output logic                        rd_ack,
  output logic signed [`SAMPLE_W-1:0] rd_sample,
  output logic                        rd_fresh
);

  readout_state_t              rd_state;
  logic signed [`SAMPLE_W-1:0] held_sample;
  logic                        fresh;
  logic                        take_req;

  assign take_req = (rd_state == RD_IDLE) && rd_req;
  assign rd_ack   = (rd_state == RD_ACK);

  // latest sample, overwritten even when unread
  always_ff @(posedge audio_clk) begin
    if (new_valid) begin
      held_sample <= new_sample;
    end
  end

  // a sample landing with the request stays fresh for the next read
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      fresh <= 1'b0;
    end else if (new_valid) begin
      fresh <= 1'b1;
    end else if (take_req) begin
      fresh <= 1'b0;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      rd_state  <= RD_IDLE;
      rd_fresh  <= 1'b0;
      rd_sample <= '0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (rd_req) begin
            rd_sample <= held_sample;
            rd_fresh  <= fresh;
            rd_state  <= RD_ACK;
          end
        end
        // outputs frozen until the host drops req
        RD_ACK: begin
          if (!rd_req) begin
            rd_state <= RD_WAIT_DROP;
          end
        end
        RD_WAIT_DROP: rd_state <= RD_IDLE;
        default:      rd_state <= RD_IDLE;
      endcase
    end
  end

  a_ack_needs_req: assert property (@(posedge audio_clk) disable iff (rst)
    $rose(rd_ack) |-> $past(rd_req));

endmodule

// ==== hw/mic_audio_top.sv ====
`include "mic_audio_defines.svh"

module mic_audio_top
  import mic_audio_pkg::*;
(
  input  logic                        audio_clk,
  input  logic                        rst,
  output logic                        bclk,
  output logic                        lrcl,
  input  logic [`MIC_COUNT-1:0]       mic_data,
  input  logic [1:0]                  mic_select,
  input  source_sel_t                 source_sel,
  input  logic signed [`SAMPLE_W-1:0] test_level,
  input  logic [1:0]                  spk_en,
  input  logic                        rd_req,
  output logic                        rd_ack,
  output logic signed [`SAMPLE_W-1:0] rd_sample,
  output logic                        rd_fresh,
  output logic                        spkl,
  output logic                        spkr
);

  logic                        frame_valid;
  logic signed [`SAMPLE_W-1:0] sample_0;
  logic signed [`SAMPLE_W-1:0] sample_1;
  logic signed [`SAMPLE_W-1:0] sample_2;
  logic signed [`SAMPLE_W-1:0] sel_sample;
  logic                        fir_valid;
  logic signed [`SAMPLE_W-1:0] fir_sample;
  logic signed [`SAMPLE_W-1:0] pdm_level;
  logic                        pdm_bit;

  i2s_mic_array i_i2s_mic_array (
    .audio_clk   (audio_clk),
    .rst         (rst),
    .mic_data    (mic_data),
    .bclk        (bclk),
    .lrcl        (lrcl),
    .frame_valid (frame_valid),
    .sample_0    (sample_0),
    .sample_1    (sample_1),
    .sample_2    (sample_2)
  );

  // microphone picked for filtering
  always_comb begin
    case (mic_select)
      2'd1:    sel_sample = sample_1;
      2'd2:    sel_sample = sample_2;
      default: sel_sample = sample_0;
    endcase
  end

  fir_decimator i_fir_decimator (
    .audio_clk  (audio_clk),
    .rst        (rst),
    .in_valid   (frame_valid),
    .in_sample  (sel_sample),
    .out_valid  (fir_valid),
    .out_sample (fir_sample)
  );

  sample_readout i_sample_readout (
    .audio_clk  (audio_clk),
    .rst        (rst),
    .new_valid  (fir_valid),
    .new_sample (fir_sample),
    .rd_req     (rd_req),
    .rd_ack     (rd_ack),
    .rd_sample  (rd_sample),
    .rd_fresh   (rd_fresh)
  );

  assign pdm_level = (source_sel == SRC_TEST) ? test_level : fir_sample;

  pdm_modulator i_pdm_modulator (
    .audio_clk (audio_clk),
    .rst       (rst),
    .level     (pdm_level),
    .pdm_bit   (pdm_bit)
  );

  // independent enable per speaker pin
  assign spkl = spk_en[0] & pdm_bit;
  assign spkr = spk_en[1] & pdm_bit;

  a_mic_select_range: assert property (@(posedge audio_clk) disable iff (rst)
    mic_select < `MIC_COUNT);

endmodule

// ==== verification/mic_audio_checker.sv ====
`include "mic_audio_defines.svh"

module mic_audio_checker
  import mic_audio_pkg::*;
(
  input  logic                        audio_clk,
  input  logic                        rst,
  input  logic                        bclk,
  input  logic                        lrcl,
  input  logic                        frame_strobe,
  input  logic signed [`SAMPLE_W-1:0] frame_word,
  input  logic                        count_en,
  input  source_sel_t                 source_sel,
  input  logic signed [`SAMPLE_W-1:0] test_level,
  input  logic [1:0]                  spk_en,
  input  logic                        rd_req,
  input  logic                        rd_ack,
  input  logic signed [`SAMPLE_W-1:0] rd_sample,
  input  logic                        rd_fresh,
  input  logic                        spkl,
  input  logic                        spkr,
  output int                          err_count,
  output int                          check_count
);

  logic signed [`SAMPLE_W-1:0] hist [3];
  logic signed [`SAMPLE_W-1:0] exp_latest;
  logic signed [`SAMPLE_W-1:0] sample_q;
  logic                        exp_fresh;
  logic                        fresh_q;
  logic                        phase;
  logic                        ack_q;
  logic                        req_q;
  logic                        count_q;
  logic                        bclk_q;
  logic                        lrcl_q;
  logic                        bclk_fell;
  int                          bclk_run;
  int                          falls;
  int                          ones_l;
  int                          ones_r;
  int                          lvl;

  // 1-3-3-1 taps, arithmetic shift, keep the low 16 bits
  function automatic logic signed [`SAMPLE_W-1:0] filter_out(
    input logic signed [`SAMPLE_W-1:0] x0, x1, x2, x3);
    int s;
    s = int'(x0) + 3 * int'(x1) + 3 * int'(x2) + int'(x3);
    s = s >>> `FIR_SHIFT;
    return s[`SAMPLE_W-1:0];
  endfunction

  // ones over 1024 cycles, compared in units of 1/64
  task automatic check_pin(input string name, input logic en, input int ones, input int level);
    int exp64;
    exp64 = level + 32768;
    check_count++;
    if (!en && ones != 0) begin
      $display("ERR %s ones=%h exp=%h (pin disabled)", name, ones, 0);
      err_count++;
    end else if (en && (ones * 64 - exp64 > 64 || exp64 - ones * 64 > 64)) begin
      $display("ERR %s ones=%h exp=%h", name, ones, exp64 / 64);
      err_count++;
    end
  endtask

  always @(posedge audio_clk) begin
    if (rst) begin
      for (int k = 0; k < 3; k++) begin
        hist[k] = '0;
      end
      exp_latest  = '0;
      exp_fresh   = 1'b0;
      sample_q    = '0;
      fresh_q     = 1'b0;
      phase       = 1'b0;
      ack_q       = 1'b0;
      req_q       = 1'b0;
      count_q     = 1'b0;
      bclk_q      = 1'b0;
      lrcl_q      = 1'b0;
      bclk_run    = 0;
      falls       = 0;
      ones_l      = 0;
      ones_r      = 0;
      err_count   = 0;
      check_count = 0;
    end else begin
      // bclk half period in audio_clk cycles
      bclk_fell = bclk_q && !bclk;
      if (bclk !== bclk_q) begin
        if (bclk_run != `BCLK_HALF) begin
          $display("ERR bclk half period got=%h exp=%h", bclk_run, `BCLK_HALF);
          err_count++;
        end
        bclk_run = 1;
      end else begin
        bclk_run++;
      end
      // lrcl moves with a bclk fall, once per slot
      if (bclk_fell) begin
        falls++;
      end
      if (lrcl !== lrcl_q) begin
        if (!bclk_fell) begin
          $display("clock error: lrcl changed away from a bclk falling edge");
          err_count++;
        end else if (falls != `SLOT_BITS) begin
          $display("ERR lrcl slot length got=%h exp=%h", falls, `SLOT_BITS);
          err_count++;
        end
        falls = 0;
      end
      // every second frame yields a filter output
      if (frame_strobe) begin
        if (phase) begin
          exp_latest = filter_out(frame_word, hist[0], hist[1], hist[2]);
          exp_fresh  = 1'b1;
        end
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = frame_word;
        phase   = !phase;
      end
      if (rd_ack && !ack_q) begin
        check_count++;
        if (rd_sample !== exp_latest) begin
          $display("ERR rd_sample got=%h exp=%h", rd_sample, exp_latest);
          err_count++;
        end
        if (rd_fresh !== exp_fresh) begin
          $display("ERR rd_fresh got=%h exp=%h", rd_fresh, exp_fresh);
          err_count++;
        end
        exp_fresh = 1'b0;
      end
      // outputs frozen while acknowledged
      if (rd_ack && ack_q) begin
        if (rd_sample !== sample_q) begin
          $display("ERR rd_sample got=%h exp=%h while rd_ack high", rd_sample, sample_q);
          err_count++;
        end
        if (rd_fresh !== fresh_q) begin
          $display("ERR rd_fresh got=%h exp=%h while rd_ack high", rd_fresh, fresh_q);
          err_count++;
        end
        if (!req_q) begin
          $display("readout error: rd_ack still high a cycle after rd_req fell");
          err_count++;
        end
      end
      if (!rd_ack && ack_q && req_q) begin
        $display("readout error: rd_ack fell while rd_req was still high");
        err_count++;
      end
      if (count_en) begin
        ones_l += int'(spkl);
        ones_r += int'(spkr);
      end else if (count_q) begin
        lvl = (source_sel == SRC_TEST) ? int'(test_level) : int'(exp_latest);
        check_pin("spkl", spk_en[0], ones_l, lvl);
        check_pin("spkr", spk_en[1], ones_r, lvl);
        ones_l = 0;
        ones_r = 0;
      end
      ack_q    = rd_ack;
      req_q    = rd_req;
      count_q  = count_en;
      sample_q = rd_sample;
      fresh_q  = rd_fresh;
      bclk_q   = bclk;
      lrcl_q   = lrcl;
    end
  end

endmodule

// ==== verification/tb_mic_audio.sv ====
`include "mic_audio_defines.svh"

module tb_mic_audio
  import mic_audio_pkg::*;
();

  localparam int ROWS      = 6;
  localparam int FRAME_CYC = 2 * `SLOT_BITS * 2 * `BCLK_HALF;
  // per row: align, four frames, align again, reads and a 1024 cycle count
  localparam int LIMIT     = (ROWS * 6 + 4) * FRAME_CYC;

  logic                        audio_clk;
  logic                        rst;
  logic                        bclk;
  logic                        lrcl;
  logic [`MIC_COUNT-1:0]       mic_data;
  logic [1:0]                  mic_select;
  source_sel_t                 source_sel;
  logic signed [`SAMPLE_W-1:0] test_level;
  logic [1:0]                  spk_en;
  logic                        rd_req;
  logic                        rd_ack;
  logic signed [`SAMPLE_W-1:0] rd_sample;
  logic                        rd_fresh;
  logic                        spkl;
  logic                        spkr;
  logic                        frame_strobe;
  logic signed [`SAMPLE_W-1:0] frame_word;
  logic                        count_en;
  int                          err_count;
  int                          check_count;

  // stimulus table
  logic [1:0]          tab_sel   [ROWS];
  source_sel_t         tab_src   [ROWS];
  logic [`SAMPLE_W-1:0] tab_level [ROWS];
  logic [1:0]          tab_en    [ROWS];
  logic [`SAMPLE_W-1:0] tab_w     [ROWS][`MIC_COUNT][4];

  integer               seed = 72870;
  int                   pos;
  int                   next;
  int                   rnd;
  int                   frame_no;
  int                   strobes;
  int                   cur_row;
  int                   cycles;
  int                   base;
  int                   errs0;
  logic                 bclk_q;
  logic                 lrcl_q;
  logic [`SAMPLE_W-1:0] cur_w [`MIC_COUNT];

  mic_audio_top i_mic_audio_top (
    .audio_clk(audio_clk), .rst(rst), .bclk(bclk), .lrcl(lrcl), .mic_data(mic_data),
    .mic_select(mic_select), .source_sel(source_sel), .test_level(test_level),
    .spk_en(spk_en), .rd_req(rd_req), .rd_ack(rd_ack), .rd_sample(rd_sample),
    .rd_fresh(rd_fresh), .spkl(spkl), .spkr(spkr)
  );

  mic_audio_checker i_mic_audio_checker (
    .audio_clk(audio_clk), .rst(rst), .bclk(bclk), .lrcl(lrcl),
    .frame_strobe(frame_strobe), .frame_word(frame_word),
    .count_en(count_en), .source_sel(source_sel), .test_level(test_level), .spk_en(spk_en),
    .rd_req(rd_req), .rd_ack(rd_ack), .rd_sample(rd_sample), .rd_fresh(rd_fresh),
    .spkl(spkl), .spkr(spkr), .err_count(err_count), .check_count(check_count)
  );

  initial begin
    audio_clk = 1'b0;
    forever #50 audio_clk = ~audio_clk;
  end

  // microphone models, slot position counted from bclk falls and lrcl edges
  always @(negedge audio_clk) begin
    frame_strobe <= 1'b0;
    bclk_q       <= bclk;
    lrcl_q       <= lrcl;
    if (rst) begin
      pos <= 0;
    end else if (bclk_q && !bclk) begin
      next = (lrcl_q && !lrcl) ? 0 : pos + 1;
      pos  <= next;
      if (next == 1) begin
        for (int m = 0; m < `MIC_COUNT; m++) begin
          cur_w[m] = tab_w[cur_row][m][frame_no % 4];
        end
        frame_no <= frame_no + 1;
      end
      if (next == 17) begin
        frame_strobe <= 1'b1;
        frame_word   <= cur_w[mic_select];
        strobes      <= strobes + 1;
      end
      // sample bits MSB first, random padding everywhere else
      for (int m = 0; m < `MIC_COUNT; m++) begin
        rnd = $random(seed);
        mic_data[m] <= (next >= 1 && next <= 16) ? cur_w[m][16-next] : rnd[0];
      end
    end
  end

  task automatic set_row(input int r, input logic [1:0] sel, input source_sel_t src,
                         input logic [15:0] lvl, input logic [1:0] en,
                         input logic [15:0] w0, w1, w2, w3);
    int v;
    tab_sel[r]   = sel;
    tab_src[r]   = src;
    tab_level[r] = lvl;
    tab_en[r]    = en;
    for (int m = 0; m < `MIC_COUNT; m++) begin
      for (int k = 0; k < 4; k++) begin
        v = $random(seed);
        tab_w[r][m][k] = v[15:0];
      end
    end
    tab_w[r][sel][0] = w0;
    tab_w[r][sel][1] = w1;
    tab_w[r][sel][2] = w2;
    tab_w[r][sel][3] = w3;
  endtask

  task automatic wait_slot_mid();
    while (pos == 40) @(negedge audio_clk);
    while (pos != 40) @(negedge audio_clk);
  endtask

  // one four-phase read as the host
  task automatic read_sample();
    rd_req = 1'b1;
    while (!rd_ack) @(negedge audio_clk);
    // host keeps req a few cycles past the ack
    repeat (3) @(negedge audio_clk);
    rd_req = 1'b0;
    while (rd_ack) @(negedge audio_clk);
    @(negedge audio_clk);
  endtask

  initial begin
    cycles = 0;
    forever begin
      @(posedge audio_clk);
      cycles++;
      if (cycles >= LIMIT) begin
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("SOME TESTS FAILED");
        $finish;
      end
    end
  end

  initial begin
    rst = 1'b1;
    mic_data = '0;
    mic_select = 2'd0;
    source_sel = SRC_MIC;
    test_level = '0;
    spk_en = 2'b00;
    rd_req = 1'b0;
    count_en = 1'b0;
    frame_strobe = 1'b0;
    frame_word = '0;
    cur_row = 0;
    frame_no = 0;
    strobes = 0;
    set_row(0, 2'd0, SRC_MIC, 16'h0000, 2'b11, 16'd1000, 16'd2000, 16'd3000, 16'd4000);
    set_row(1, 2'd1, SRC_TEST, 16'h4000, 2'b01, 16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF);
    set_row(2, 2'd2, SRC_TEST, -16'sd20000, 2'b10, 16'h8000, 16'h8000, 16'h8000, 16'h8000);
    set_row(3, 2'd0, SRC_MIC, 16'h0000, 2'b11, 16'hF000, 16'hE123, 16'h1234, 16'hFFFF);
    set_row(4, 2'd2, SRC_TEST, 16'h7FFF, 2'b01, 16'h0001, 16'h8001, 16'h7FFE, 16'h0002);
    set_row(5, 2'd1, SRC_MIC, 16'h0000, 2'b01, 16'h5A5A, 16'hA5A5, 16'h0F0F, 16'hF0F0);
    repeat (16) @(negedge audio_clk);
    rst = 1'b0;
    for (int r = 0; r < ROWS; r++) begin
      wait_slot_mid();
      mic_select = tab_sel[r];
      source_sel = tab_src[r];
      test_level = tab_level[r];
      spk_en     = tab_en[r];
      cur_row    = r;
      base       = strobes;
      while (strobes < base + 4) @(negedge audio_clk);
      wait_slot_mid();
      errs0 = err_count;
      // second read finds nothing new
      read_sample();
      read_sample();
      count_en = 1'b1;
      repeat (1024) @(negedge audio_clk);
      count_en = 1'b0;
      repeat (4) @(negedge audio_clk);
      if (err_count == errs0) begin
        $display("row %0d passed", r);
      end else begin
        $display("row %0d failed with %0d errors", r, err_count - errs0);
      end
    end
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/mic_audio_pkg.sv
hw/i2s_mic_array.sv
hw/fir_decimator.sv
hw/pdm_modulator.sv
hw/sample_readout.sv
hw/mic_audio_top.sv
verification/mic_audio_checker.sv
verification/tb_mic_audio.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mic_audio
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) hw/mic_audio_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
